// File: common/coreCfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and register width
`define DATA_W 32

// Architectural registers, r0 reads as zero
`define REG_N 32

// Data memory size in words
`define MEM_DEPTH 64

`endif

// File: common/corePkg.sv
`include "coreCfg.svh"

package corePkg;

  typedef logic [$clog2(`REG_N)-1:0] regIdxT;

  // Major opcodes, octal as in the soft core encoding
  typedef enum logic [5:0] {
    opAdd  = 6'o00,
    opAddi = 6'o10,
    opOr   = 6'o40,
    opAnd  = 6'o41,
    opXor  = 6'o42,
    opSrl  = 6'o44,
    opMov  = 6'o45,
    opOri  = 6'o50,
    opAndi = 6'o51,
    opXori = 6'o52,
    opLw   = 6'o62,
    opSw   = 6'o66,
    opLwi  = 6'o72,
    opSwi  = 6'o76
  } opcodeT;

  // Operand source, selImm only valid for operand B
  typedef enum logic [1:0] {
    selReg = 2'd0,
    selFwd = 2'd1,
    selRam = 2'd2,
    selImm = 2'd3
  } srcSelT;

  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluLog   = 3'd1,
    aluShift = 3'd2,
    aluMov   = 3'd3
  } aluSelT;

  typedef enum logic [1:0] {
    dstAlu  = 2'd0,
    dstRam  = 2'd1,
    dstNone = 2'd2
  } dstSelT;

  // Instruction word, imm16 is {rb, alt}
  typedef struct packed {
    opcodeT      opc;
    regIdxT      rd;
    regIdxT      ra;
    regIdxT      rb;
    logic [10:0] alt;
  } instrT;

  // Execute stage controls
  typedef struct packed {
    srcSelT             mxSrc;
    srcSelT             mxTgt;
    aluSelT             mxAlu;
    logic [1:0]         logFn;  // 0 OR, 1 AND, 2 XOR
    logic [`DATA_W-1:0] imm;    // Already sign extended
    logic               memRd;
    logic               memWr;
  } xCtrlT;

  typedef struct packed {
    logic               valid;
    regIdxT             rw;
    logic [`DATA_W-1:0] data;
  } wbT;

endpackage

// File: ctrl/pipeCtrl.sv
`include "coreCfg.svh"

module pipeCtrl import corePkg::*; (
  input  logic   gclk,
  input  logic   grst,
  input  logic   step,
  input  instrT  iword,
  output regIdxT raAddr,
  output regIdxT rbAddr,
  output xCtrlT  xCtrl,
  output dstSelT rMxDst,
  output regIdxT rRw,
  output logic   rRwValid,
  output logic   memLoad,
  output logic   memAccess
);

  logic        isLoad;
  logic        isStore;
  aluSelT      dMxAlu;
  dstSelT      dMxDst;
  srcSelT      dMxSrc;
  srcSelT      dMxTgt;
  logic        dRwValid;
  logic [15:0] imm16;
  xCtrlT       dCtrl;

  // Execute stage destination
  dstSelT      xMxDst;
  regIdxT      xRw;
  logic        xRwValid;

  logic        aFwdRam;
  logic        aFwdAlu;
  logic        bFwdRam;
  logic        bFwdAlu;

  // Opcode class decode
  always_comb begin
    dMxAlu  = aluAdd;
    dMxDst  = dstNone;
    isLoad  = 1'b0;
    isStore = 1'b0;
    case (iword.opc)
      opAdd, opAddi: dMxDst = dstAlu;
      opOr, opAnd, opXor, opOri, opAndi, opXori: begin
        dMxAlu = aluLog;
        dMxDst = dstAlu;
      end
      opSrl: begin
        dMxAlu = aluShift;
        dMxDst = dstAlu;
      end
      opMov: begin
        dMxAlu = aluMov;
        dMxDst = dstAlu;
      end
      opLw, opLwi: begin
        dMxDst = dstRam;
        isLoad = 1'b1;
      end
      opSw: begin
        dMxAlu  = aluMov;  // Address is ra alone
        isStore = 1'b1;
      end
      opSwi: isStore = 1'b1;  // Address is ra + imm
      default: dMxDst = dstNone;  // Unknown opcodes retire as NOP
    endcase
  end

  // Stores read their data register rd through port B. The bank is read at
  // decode, so rd has to be produced at least two instructions earlier
  assign raAddr = iword.ra;
  assign rbAddr = isStore ? iword.rd : iword.rb;

  // Hazard against the instruction now in execute
  assign aFwdRam = xRwValid && (xRw == iword.ra) && (xMxDst == dstRam);
  assign aFwdAlu = xRwValid && (xRw == iword.ra) && (xMxDst == dstAlu);
  assign bFwdRam = xRwValid && (xRw == iword.rb) && (xMxDst == dstRam);
  assign bFwdAlu = xRwValid && (xRw == iword.rb) && (xMxDst == dstAlu);

  always_comb begin
    if (aFwdRam) begin
      dMxSrc = selRam;  // Load still in flight
    end else if (aFwdAlu) begin
      dMxSrc = selFwd;
    end else begin
      dMxSrc = selReg;
    end
    if (iword.opc[3]) begin
      dMxTgt = selImm;
    end else if (bFwdRam) begin
      dMxTgt = selRam;
    end else if (bFwdAlu) begin
      dMxTgt = selFwd;
    end else begin
      dMxTgt = selReg;
    end
  end

  assign imm16    = {iword.rb, iword.alt};
  assign dRwValid = (dMxDst != dstNone) && (iword.rd != '0);  // r0 writes dropped

  always_comb begin
    dCtrl.mxSrc = dMxSrc;
    dCtrl.mxTgt = dMxTgt;
    dCtrl.mxAlu = dMxAlu;
    dCtrl.logFn = iword.opc[1:0];
    dCtrl.imm   = {{(`DATA_W-16){imm16[15]}}, imm16};
    dCtrl.memRd = isLoad;
    dCtrl.memWr = isStore;
  end

  // Decode to execute, execute to writeback
  always_ff @(posedge gclk) begin
    if (grst) begin
      xCtrl    <= '0;
      xMxDst   <= dstNone;
      xRw      <= '0;
      xRwValid <= 1'b0;
      rMxDst   <= dstNone;
      rRw      <= '0;
      rRwValid <= 1'b0;
    end else if (step) begin
      xCtrl    <= dCtrl;
      xMxDst   <= dMxDst;
      xRw      <= iword.rd;
      xRwValid <= dRwValid;
      rMxDst   <= xMxDst;
      rRw      <= xRw;
      rRwValid <= xRwValid;
    end
  end

  // Class of the instruction last taken in or NOP after reset
  assign memLoad   = xCtrl.memRd;
  assign memAccess = xCtrl.memRd | xCtrl.memWr;

  aWbNotR0: assert property (@(posedge gclk) disable iff (grst)
    rRwValid |-> rRw != '0);

  // A store in execute never selects the RAM destination
  aStoreNoDst: assert property (@(posedge gclk) disable iff (grst)
    xCtrl.memWr |-> xMxDst != dstRam);

endmodule

// File: hw/regBank.sv
`include "coreCfg.svh"

module regBank import corePkg::*; (
  input  logic               gclk,
  input  logic               grst,
  input  logic               step,
  input  regIdxT             raAddr,
  input  regIdxT             rbAddr,
  input  wbT                 wb,
  output logic [`DATA_W-1:0] raData,
  output logic [`DATA_W-1:0] rbData
);

  logic [`DATA_W-1:0] regs [`REG_N];

  // Read with write-through from the retiring result
  function automatic logic [`DATA_W-1:0] readPort(input regIdxT addr);
    if (addr == '0) begin
      return '0;
    end else if (wb.valid && (wb.rw == addr)) begin
      return wb.data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge gclk) begin
    if (step) begin
      if (wb.valid) begin
        regs[wb.rw] <= wb.data;
      end
      raData <= readPort(raAddr);  // Aligned with execute
      rbData <= readPort(rbAddr);
    end
  end

  aNoR0Write: assert property (@(posedge gclk) disable iff (grst)
    step && wb.valid |-> wb.rw != '0);

endmodule

// File: hw/aluUnit.sv
`include "coreCfg.svh"

module aluUnit import corePkg::*; (
  input  logic               gclk,
  input  logic               grst,
  input  logic               step,
  input  xCtrlT              xCtrl,
  input  logic [`DATA_W-1:0] raData,
  input  logic [`DATA_W-1:0] rbData,
  input  logic [`DATA_W-1:0] ramData,
  output logic [`DATA_W-1:0] aluRes,
  output logic [`DATA_W-1:0] fwdData
);

  logic [`DATA_W-1:0] opA;
  logic [`DATA_W-1:0] opB;
  logic [`DATA_W-1:0] logRes;

  // Operand muxes
  always_comb begin
    case (xCtrl.mxSrc)
      selFwd:  opA = fwdData;
      selRam:  opA = ramData;
      default: opA = raData;
    endcase
    case (xCtrl.mxTgt)
      selFwd:  opB = fwdData;
      selRam:  opB = ramData;
      selImm:  opB = xCtrl.imm;
      default: opB = rbData;
    endcase
  end

  always_comb begin
    case (xCtrl.logFn)
      2'd0:    logRes = opA | opB;
      2'd1:    logRes = opA & opB;
      default: logRes = opA ^ opB;
    endcase
  end

  always_comb begin
    case (xCtrl.mxAlu)
      aluLog:   aluRes = logRes;
      aluShift: aluRes = {1'b0, opA[`DATA_W-1:1]};  // Logical shift by one
      aluMov:   aluRes = opA;
      default:  aluRes = opA + opB;  // Also load and store address
    endcase
  end

  // Result register, feeds writeback and execute forwarding
  always_ff @(posedge gclk) begin
    if (grst) begin
      fwdData <= '0;
    end else if (step) begin
      fwdData <= aluRes;
    end
  end

endmodule

// File: hw/dataMem.sv
`include "coreCfg.svh"

module dataMem (
  input  logic               gclk,
  input  logic               grst,
  input  logic               step,
  input  logic [`DATA_W-1:0] addr,
  input  logic [`DATA_W-1:0] wdata,
  input  logic               memRd,
  input  logic               memWr,
  output logic [`DATA_W-1:0] ramData
);

  localparam int AW = $clog2(`MEM_DEPTH);

  logic [`DATA_W-1:0] mem [`MEM_DEPTH];
  logic [AW-1:0]      wordAddr;

  assign wordAddr = addr[AW+1:2];  // Byte address to word index

  always_ff @(posedge gclk) begin
    if (step) begin
      if (memWr) begin
        mem[wordAddr] <= wdata;
      end
      if (memRd) begin
        ramData <= mem[wordAddr];  // Held until the next load
      end
    end
  end

  aAddrInRange: assert property (@(posedge gclk) disable iff (grst)
    step && (memRd || memWr) |-> addr[`DATA_W-1:2] < `MEM_DEPTH);

endmodule

// File: hw/coreTop.sv
`include "coreCfg.svh"

module coreTop import corePkg::*; (
  input  logic  gclk,
  input  logic  grst,
  input  logic  step,
  input  instrT iword,
  output wbT    wb,
  output logic  memLoad,
  output logic  memAccess
);

  regIdxT             raAddr;
  regIdxT             rbAddr;
  regIdxT             rRw;
  logic               rRwValid;
  xCtrlT              xCtrl;
  dstSelT             rMxDst;
  logic [`DATA_W-1:0] raData;
  logic [`DATA_W-1:0] rbData;
  logic [`DATA_W-1:0] aluRes;
  logic [`DATA_W-1:0] fwdData;
  logic [`DATA_W-1:0] ramData;

  pipeCtrl uCtrl (
    .gclk      (gclk),
    .grst      (grst),
    .step      (step),
    .iword     (iword),
    .raAddr    (raAddr),
    .rbAddr    (rbAddr),
    .xCtrl     (xCtrl),
    .rMxDst    (rMxDst),
    .rRw       (rRw),
    .rRwValid  (rRwValid),
    .memLoad   (memLoad),
    .memAccess (memAccess)
  );

  regBank uRegs (
    .gclk   (gclk),
    .grst   (grst),
    .step   (step),
    .raAddr (raAddr),
    .rbAddr (rbAddr),
    .wb     (wb),
    .raData (raData),
    .rbData (rbData)
  );

  aluUnit uAlu (
    .gclk    (gclk),
    .grst    (grst),
    .step    (step),
    .xCtrl   (xCtrl),
    .raData  (raData),
    .rbData  (rbData),
    .ramData (ramData),
    .aluRes  (aluRes),
    .fwdData (fwdData)
  );

  dataMem uMem (
    .gclk    (gclk),
    .grst    (grst),
    .step    (step),
    .addr    (aluRes),
    .wdata   (rbData),  // Store data register read through port B
    .memRd   (xCtrl.memRd),
    .memWr   (xCtrl.memWr),
    .ramData (ramData)
  );

  // Writeback mux
  assign wb.valid = rRwValid;
  assign wb.rw    = rRw;
  assign wb.data  = (rMxDst == dstRam) ? ramData : fwdData;

endmodule

// File: testbench/coreTb.sv
`include "coreCfg.svh"

module coreTb import corePkg::*; ();

  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 5;
  localparam logic [15:0] TOP_ADDR = 16'((`MEM_DEPTH - 1) * 4);  // Last memory word

  typedef struct packed {
    logic [31:0] word;
    logic        expValid;
    regIdxT      expRw;
    logic [31:0] expData;
    logic        expLoad;
    logic        expAccess;
  } rowT;

  logic  gclk;
  logic  grst;
  logic  step;
  instrT iword;
  wbT    wb;
  logic  memLoad;
  logic  memAccess;

  rowT   rows[$];
  string rowName[$];
  int    pending[$];  // Rows taken in, waiting for writeback
  wbT    heldWb;
  logic  heldLoad;
  logic  heldAccess;
  int    checks = 0;
  int    errors = 0;
  logic [31:0] rngState = 32'd2641;

  coreTop dut (
    .gclk      (gclk),
    .grst      (grst),
    .step      (step),
    .iword     (iword),
    .wb        (wb),
    .memLoad   (memLoad),
    .memAccess (memAccess)
  );

  initial begin
    gclk = 1'b0;
    forever #(PERIOD / 2) gclk = ~gclk;
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [31:0] regForm(opcodeT opc, int rd, int ra, int rb);
    return {opc, rd[4:0], ra[4:0], rb[4:0], 11'd0};
  endfunction

  function automatic logic [31:0] immForm(opcodeT opc, int rd, int ra, logic [15:0] imm);
    return {opc, rd[4:0], ra[4:0], imm};
  endfunction

  task automatic addRow(string name, logic [31:0] word, logic v, regIdxT rw,
                        logic [31:0] data, logic ld, logic acc);
    rowT r;
    r.word      = word;
    r.expValid  = v;
    r.expRw     = rw;
    r.expData   = data;
    r.expLoad   = ld;
    r.expAccess = acc;
    rows.push_back(r);
    rowName.push_back(name);
  endtask

  task automatic aluRow(string name, logic [31:0] word, regIdxT rw, logic [31:0] data);
    addRow(name, word, 1'b1, rw, data, 1'b0, 1'b0);
  endtask

  task automatic loadRow(string name, logic [31:0] word, regIdxT rw, logic [31:0] data);
    addRow(name, word, 1'b1, rw, data, 1'b1, 1'b1);
  endtask

  // No writeback expected
  task automatic quietRow(string name, logic [31:0] word, logic acc);
    addRow(name, word, 1'b0, '0, '0, 1'b0, acc);
  endtask

  task automatic buildTable();
    aluRow("addi r1", immForm(opAddi, 1, 0, 16'h0123), 5'd1, 32'h0000_0123);
    aluRow("ori r2", immForm(opOri, 2, 0, 16'h5A5A), 5'd2, 32'h0000_5A5A);
    aluRow("addi neg r3", immForm(opAddi, 3, 0, 16'hFFF0), 5'd3, 32'hFFFF_FFF0);
    aluRow("add r4", regForm(opAdd, 4, 1, 2), 5'd4, 32'h0000_5B7D);
    aluRow("xor fwd A", regForm(opXor, 5, 4, 3), 5'd5, 32'hFFFF_A48D);
    aluRow("and fwd B", regForm(opAnd, 6, 2, 5), 5'd6, 32'h0000_0008);
    aluRow("srl bypass", regForm(opSrl, 7, 5, 0), 5'd7, 32'h7FFF_D246);
    aluRow("mov fwd", regForm(opMov, 8, 7, 0), 5'd8, 32'h7FFF_D246);
    aluRow("andi fwd", immForm(opAndi, 9, 8, 16'h0FF0), 5'd9, 32'h0000_0240);
    aluRow("xori sext", immForm(opXori, 10, 9, 16'h8001), 5'd10, 32'hFFFF_8241);
    aluRow("or r11", regForm(opOr, 11, 1, 6), 5'd11, 32'h0000_012B);
    quietRow("swi word4", immForm(opSwi, 5, 0, 16'h0010), 1'b1);
    quietRow("sw word2", regForm(opSw, 10, 6, 0), 1'b1);
    loadRow("lw word2", regForm(opLw, 12, 6, 0), 5'd12, 32'hFFFF_8241);
    aluRow("add after lw", regForm(opAdd, 13, 12, 1), 5'd13, 32'hFFFF_8364);
    loadRow("lwi word4", immForm(opLwi, 14, 0, 16'h0010), 5'd14, 32'hFFFF_A48D);
    aluRow("xor after lwi", regForm(opXor, 15, 1, 14), 5'd15, 32'hFFFF_A5AE);
    quietRow("addi r0", immForm(opAddi, 0, 0, 16'h7777), 1'b0);
    aluRow("or reads r0", regForm(opOr, 16, 0, 2), 5'd16, 32'h0000_5A5A);
    aluRow("add r0 r0", regForm(opAdd, 17, 0, 0), 5'd17, 32'h0000_0000);
    quietRow("swi top", immForm(opSwi, 13, 0, TOP_ADDR), 1'b1);
    loadRow("lwi top", immForm(opLwi, 18, 0, TOP_ADDR), 5'd18, 32'hFFFF_8364);
    loadRow("lw rb index", regForm(opLw, 19, 0, 6), 5'd19, 32'hFFFF_8241);
    aluRow("srl after lw", regForm(opSrl, 20, 19, 0), 5'd20, 32'h7FFF_C120);
    // Drain so the last result reaches wb
    quietRow("drain 0", regForm(opAdd, 0, 0, 0), 1'b0);
    quietRow("drain 1", regForm(opAdd, 0, 0, 0), 1'b0);
  endtask

  task automatic checkBit(string name, string field, logic expVal, logic actVal);
    checks++;
    assert (actVal === expVal) else begin
      errors++;
      $display("CHECK FAILED %s %s expected %0b actual %0b", name, field, expVal, actVal);
    end
  endtask

  task automatic checkWord(string name, string field, logic [31:0] expVal,
                           logic [31:0] actVal);
    checks++;
    assert (actVal === expVal) else begin
      errors++;
      $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h",
               name, field, expVal, actVal);
    end
  endtask

  // Outputs one half period after a step
  task automatic checkStep(int idx);
    int j;
    pending.push_back(idx);
    checkBit(rowName[idx], "memLoad", rows[idx].expLoad, memLoad);
    checkBit(rowName[idx], "memAccess", rows[idx].expAccess, memAccess);
    if (pending.size() == 2) begin
      j = pending.pop_front();
      checkBit(rowName[j], "wb.valid", rows[j].expValid, wb.valid);
      if (rows[j].expValid) begin
        checkWord(rowName[j], "wb.rw", 32'(rows[j].expRw), 32'(wb.rw));
        checkWord(rowName[j], "wb.data", rows[j].expData, wb.data);
      end
    end
    heldWb     = wb;
    heldLoad   = memLoad;
    heldAccess = memAccess;
  endtask

  task automatic checkHeld(string name);
    checkBit(name, "held wb.valid", heldWb.valid, wb.valid);
    checkWord(name, "held wb.rw", 32'(heldWb.rw), 32'(wb.rw));
    checkWord(name, "held wb.data", heldWb.data, wb.data);
    checkBit(name, "held memLoad", heldLoad, memLoad);
    checkBit(name, "held memAccess", heldAccess, memAccess);
  endtask

  initial begin
    int gaps;
    grst  = 1'b1;
    step  = 1'b0;
    iword = '0;
    buildTable();
    repeat (RST_CYCLES) @(posedge gclk);
    @(negedge gclk);
    grst = 1'b0;
    checkBit("reset", "wb.valid", 1'b0, wb.valid);
    checkBit("reset", "memLoad", 1'b0, memLoad);
    checkBit("reset", "memAccess", 1'b0, memAccess);
    heldWb     = wb;
    heldLoad   = memLoad;
    heldAccess = memAccess;

    for (int i = 0; i < rows.size(); i++) begin
      gaps = int'(nextRand() % 32'd3);
      repeat (gaps) begin
        step  = 1'b0;
        iword = instrT'(nextRand());  // Junk word, must be ignored
        @(negedge gclk);
        checkHeld({"gap before ", rowName[i]});
      end
      step  = 1'b1;
      iword = instrT'(rows[i].word);
      @(negedge gclk);
      checkStep(i);
    end
    step = 1'b0;

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog, generous bound on rows plus gaps
  initial begin
    int limit;
    #1;
    limit = 4 * rows.size() * 2 + RST_CYCLES;
    repeat (limit) @(posedge gclk);
    $display("Timeout: run did not finish within %0d clock cycles", limit);
    $display("Test failed");
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/corePkg.sv
ctrl/pipeCtrl.sv
hw/regBank.sv
hw/aluUnit.sv
hw/dataMem.sv
hw/coreTop.sv
testbench/coreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
